// File: test/dbg_station_tb.sv
`timescale 1ns/1ns

module dbg_station_tb;
   import dbg_pkg::*;
   import reg_pkg::*;

   localparam int          CLK_PERIOD   = 8;
   localparam int          RESP_TIMEOUT = 200;  // cycles allowed per response packet
   localparam int          TEST_PACKETS = 56;
   localparam logic [9:0]  BASE_ID      = 10'h040;
   localparam logic [9:0]  SCM_ID       = BASE_ID;
   localparam logic [9:0]  TS_ID        = BASE_ID + 10'd1;
   localparam logic [15:0] SCM_VER      = 16'h0102;
   localparam logic [15:0] TS_VER       = 16'h0310;
   localparam logic [15:0] SCRATCH_VAL  = 16'hbeef;

   logic        clk;
   logic        rst;
   dii_flit_t   in_flit;
   logic        in_ready;
   dii_flit_t   out_flit;
   logic        out_ready;
   logic        sys_stall;
   logic        sys_rst;

   integer      seed = 32'h28a6e164;
   int          value_errors = 0;
   int          protocol_errors = 0;
   int          pkts_done = 0;   // complete packets seen by the collector
   int          pkts_taken = 0;  // packets already checked
   bit          valid_seen = 1'b0;
   bit          out_block = 1'b0;
   logic [9:0]  src_id = 10'h100;
   dii_flit_t   resp_q [$];
   logic [15:0] rx_data [4];
   bit          rx_first [4];
   bit          rx_last [4];
   int          rx_n;

   dbg_station #(
      .BASE_ID     (BASE_ID),
      .SCM_VERSION (SCM_VER),
      .TS_VERSION  (TS_VER)
   ) dbg_station_inst (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_ready  (in_ready),
      .out_flit  (out_flit),
      .out_ready (out_ready),
      .sys_stall (sys_stall),
      .sys_rst   (sys_rst)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(TEST_PACKETS * RESP_TIMEOUT * CLK_PERIOD);
      $display("watchdog expired before the test sequence completed");
      $display("TB FAILED");
      $finish;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // response collector with random back-pressure
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial begin : collector
      dii_flit_t held_flit;
      bit        held;
      bit        block_now;
      bit        ready_draw;
      held       = 1'b0;
      held_flit  = '0;
      block_now  = 1'b0;
      ready_draw = 1'b0;
      out_ready  = 1'b0;
      forever begin
         @(posedge clk);
         block_now  = out_block;
         ready_draw = ({$random(seed)} % 4) != 0;
         if (held) begin
            assert (out_flit === held_flit) else begin
               value_errors++;
               $display("error at %0t ns: out_flit expected %h got %h", $time, held_flit,
                        out_flit);
            end
         end
         if (out_flit.valid) begin
            valid_seen = 1'b1;
         end
         if (out_flit.valid && out_ready) begin
            resp_q.push_back(out_flit);
            if (out_flit.last) begin
               pkts_done++;
            end
         end
         held      = out_flit.valid && !out_ready;  // flit must not move until taken
         held_flit = out_flit;
         #1;
         out_ready = ready_draw && !block_now;
      end
   end

   task automatic check_field(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
      assert (act === exp) else begin
         value_errors++;
         $display("error at %0t ns: %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_count(input string rule, input bit ok, input logic [31:0] ref_v,
                              input logic [31:0] act);
      assert (ok) else begin
         value_errors++;
         $display("error at %0t ns: timestamp count expected %s %h got %h", $time, rule,
                  ref_v, act);
      end
   endtask

   task automatic send_raw(input logic [15:0] w0, w1, w2, w3, input int n,
                           input bit mark_first);
      logic [15:0] words [4];
      int          gap;
      words[0] = w0;
      words[1] = w1;
      words[2] = w2;
      words[3] = w3;
      for (int i = 0; i < n; i++) begin
         gap = {$random(seed)} % 3;  // idle cycles before this flit
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         in_flit.valid = 1'b1;
         in_flit.first = mark_first && (i == 0);
         in_flit.last  = (i == n - 1);
         in_flit.data  = words[i];
         do begin
            @(posedge clk);
         end while (!in_ready);
         #1;
         in_flit = '0;
      end
   endtask

   task automatic send_request(input logic [9:0] dest, input logic [3:0] kind,
                               input logic [15:0] addr, input logic [15:0] wdata,
                               input logic [9:0] src);
      send_raw({6'h00, dest}, {kind, 2'b00, src}, addr, wdata,
               (kind == REQ_WRITE_REG) ? 4 : 3, 1'b1);
   endtask

   task automatic pop_response();
      dii_flit_t f;
      int        t;
      t    = 0;
      rx_n = 0;
      for (int i = 0; i < 4; i++) begin
         rx_data[i]  = 16'h0000;
         rx_first[i] = 1'b0;
         rx_last[i]  = 1'b0;
      end
      while (pkts_done == pkts_taken && t < RESP_TIMEOUT) begin
         @(posedge clk);
         #1;
         t++;
      end
      assert (pkts_done != pkts_taken) else begin
         protocol_errors++;
         $display("no response packet arrived within %0d cycles", RESP_TIMEOUT);
      end
      if (pkts_done != pkts_taken) begin
         pkts_taken++;
         do begin
            f = resp_q.pop_front();
            rx_data[rx_n]  = f.data;
            rx_first[rx_n] = f.first;
            rx_last[rx_n]  = f.last;
            rx_n++;
         end while (!f.last && rx_n < 4);
      end
   endtask

   task automatic check_response(input logic [9:0] src, input logic [9:0] mod, input bit wr,
                                 input bit exp_err);
      logic [3:0] exp_type;
      int         exp_n;
      if (wr) begin
         exp_type = exp_err ? RESP_WRITE_REG_ERROR : RESP_WRITE_REG;
      end else begin
         exp_type = exp_err ? RESP_READ_REG_ERROR : RESP_READ_REG;
      end
      exp_n = wr ? 2 : 3;
      if (rx_n == 0) begin
         return;
      end
      assert (rx_n == exp_n) else begin
         protocol_errors++;
         $display("response to source %h has %0d flits instead of %0d", src, rx_n, exp_n);
      end
      for (int i = 0; i < rx_n; i++) begin
         assert (rx_first[i] == (i == 0) && rx_last[i] == (i == rx_n - 1)) else begin
            protocol_errors++;
            $display("response to source %h has wrong first or last marks on flit %0d",
                     src, i);
         end
      end
      check_field("response flit 0", {6'h00, src}, rx_data[0]);
      check_field("response flit 1", {exp_type, 2'b00, mod}, rx_data[1]);
   endtask

   task automatic read_reg(input logic [9:0] dest, input logic [15:0] addr, input bit exp_err,
                           output logic [15:0] value);
      logic [9:0] src;
      src    = src_id;
      src_id = src_id + 10'd1;
      send_request(dest, REQ_READ_REG, addr, 16'h0000, src);
      pop_response();
      check_response(src, dest, 1'b0, exp_err);
      value = rx_data[2];
      if (exp_err) begin
         check_field("error read value", 16'h0000, value);
      end
   endtask

   task automatic write_reg(input logic [9:0] dest, input logic [15:0] addr,
                            input logic [15:0] wdata, input bit exp_err);
      logic [9:0] src;
      src    = src_id;
      src_id = src_id + 10'd1;
      send_request(dest, REQ_WRITE_REG, addr, wdata, src);
      pop_response();
      check_response(src, dest, 1'b1, exp_err);
   endtask

   task automatic expect_read(input logic [9:0] dest, input logic [15:0] addr,
                              input logic [15:0] exp);
      logic [15:0] v;
      read_reg(dest, addr, 1'b0, v);
      check_field($sformatf("module %h register %h", dest, addr), exp, v);
   endtask

   task automatic read_count(output logic [31:0] count);
      logic [15:0] lo;
      logic [15:0] hi;
      read_reg(TS_ID, TS_COUNT_LO, 1'b0, lo);  // low first, high comes from the snapshot
      read_reg(TS_ID, TS_COUNT_HI, 1'b0, hi);
      count = {hi, lo};
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial begin : stimulus
      logic [15:0] v;
      logic [31:0] c_a;
      logic [31:0] c_b;
      logic [9:0]  src_a;
      logic [9:0]  src_b;
      bit [1:0]    seen;
      rst     = 1'b1;
      in_flit = '0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      repeat (2) @(posedge clk);
      #1;

      expect_read(SCM_ID, REG_MODID, MOD_TYPE_SCM);
      expect_read(SCM_ID, REG_VERSION, SCM_VER);
      expect_read(TS_ID, REG_MODID, MOD_TYPE_TIMESTAMP);
      expect_read(TS_ID, REG_VERSION, TS_VER);

      write_reg(SCM_ID, SCM_SCRATCH, SCRATCH_VAL, 1'b0);
      expect_read(SCM_ID, SCM_SCRATCH, SCRATCH_VAL);
      write_reg(SCM_ID, SCM_STALL, 16'h0001, 1'b0);
      expect_read(SCM_ID, SCM_STALL, 16'h0001);
      check_field("sys_stall", 16'h0001, {15'h0000, sys_stall});
      write_reg(SCM_ID, SCM_STALL, 16'h0000, 1'b0);
      expect_read(SCM_ID, SCM_STALL, 16'h0000);
      check_field("sys_stall", 16'h0000, {15'h0000, sys_stall});
      write_reg(SCM_ID, SCM_RST, 16'h0001, 1'b0);
      expect_read(SCM_ID, SCM_RST, 16'h0001);
      check_field("sys_rst", 16'h0001, {15'h0000, sys_rst});
      write_reg(SCM_ID, SCM_RST, 16'h0000, 1'b0);
      check_field("sys_rst", 16'h0000, {15'h0000, sys_rst});

      // counter is disabled out of reset
      read_count(c_a);
      check_count("equal to", c_a == 32'd0, 32'd0, c_a);
      repeat (20) @(posedge clk);
      #1;
      read_count(c_a);
      check_count("equal to", c_a == 32'd0, 32'd0, c_a);
      write_reg(TS_ID, TS_CTRL, 16'h0001, 1'b0);
      read_count(c_a);
      repeat (10) @(posedge clk);
      #1;
      read_count(c_b);
      check_count("above", c_b > c_a, c_a, c_b);
      write_reg(SCM_ID, SCM_STALL, 16'h0001, 1'b0);
      read_count(c_a);
      repeat (10) @(posedge clk);
      #1;
      read_count(c_b);
      check_count("equal to", c_b == c_a, c_a, c_b);
      write_reg(SCM_ID, SCM_STALL, 16'h0000, 1'b0);
      repeat (100) @(posedge clk);
      #1;
      read_count(c_a);
      check_count("above", c_a > c_b, c_b, c_a);
      write_reg(TS_ID, TS_CTRL, 16'h0003, 1'b0);  // keep enabled and clear
      read_count(c_b);
      check_count("below", c_b < c_a, c_a, c_b);

      read_reg(SCM_ID, 16'h0005, 1'b1, v);
      read_reg(TS_ID, 16'h0300, 1'b1, v);
      write_reg(SCM_ID, REG_MODID, 16'h5a5a, 1'b1);
      expect_read(SCM_ID, REG_MODID, MOD_TYPE_SCM);
      write_reg(SCM_ID, 16'h0203, 16'h0001, 1'b1);
      expect_read(SCM_ID, SCM_SCRATCH, SCRATCH_VAL);
      expect_read(SCM_ID, SCM_STALL, 16'h0000);
      write_reg(TS_ID, 16'h0210, 16'h0000, 1'b1);
      expect_read(TS_ID, TS_CTRL, 16'h0001);

      // malformed packets, none of them may produce a response
      valid_seen = 1'b0;
      send_raw({6'h00, SCM_ID}, {REQ_READ_REG, 2'b00, src_id}, SCM_SCRATCH, 16'h0000, 3, 1'b0);
      send_raw({6'h00, SCM_ID}, {4'd5, 2'b00, src_id}, SCM_SCRATCH, 16'h0000, 3, 1'b1);
      send_raw({6'h00, BASE_ID + 10'd2}, {REQ_READ_REG, 2'b00, src_id}, REG_MODID, 16'h0000,
               3, 1'b1);
      send_raw({6'h00, TS_ID}, {REQ_READ_REG, 2'b00, src_id}, REG_MODID, 16'h1234, 4, 1'b1);
      repeat (20) @(posedge clk);
      #1;
      assert (!valid_seen) else begin
         protocol_errors++;
         $display("a dropped packet produced response flits");
      end
      expect_read(SCM_ID, SCM_SCRATCH, SCRATCH_VAL);

      for (int r = 0; r < 4; r++) begin
         src_a  = src_id;
         src_b  = src_id + 10'd1;
         src_id = src_id + 10'd2;
         seen   = 2'b00;
         out_block = (r % 2 == 0);  // even rounds queue both responses behind a stalled output
         send_request(SCM_ID, REQ_READ_REG, SCM_SCRATCH, 16'h0000, src_a);
         send_request(TS_ID, REQ_READ_REG, REG_VERSION, 16'h0000, src_b);
         out_block = 1'b0;
         for (int k = 0; k < 2; k++) begin
            pop_response();
            if (rx_data[1][9:0] == TS_ID) begin
               seen[1] = 1'b1;
               check_response(src_b, TS_ID, 1'b0, 1'b0);
               check_field("merged timestamp version", TS_VER, rx_data[2]);
            end else begin
               seen[0] = 1'b1;
               check_response(src_a, SCM_ID, 1'b0, 1'b0);
               check_field("merged scratch value", SCRATCH_VAL, rx_data[2]);
            end
         end
         assert (seen == 2'b11) else begin
            protocol_errors++;
            $display("back-to-back requests did not get one response from each module");
         end
      end

      $display("summary: %0d value errors, %0d protocol errors", value_errors,
               protocol_errors);
      if (value_errors == 0 && protocol_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: verilog.f
verilog/dbg_pkg.sv
verilog/reg_pkg.sv
verilog/reg_access_port.sv
verilog/scm_regs.sv
verilog/timestamp_unit.sv
verilog/dbg_station_router.sv
verilog/dbg_station.sv
test/dbg_station_tb.sv

// File: verilog/dbg_pkg.sv
package dbg_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // flit channel
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef struct packed {
      logic        valid;
      logic        first;  // marks flit 0 of a packet
      logic        last;   // marks the final flit of a packet
      logic [15:0] data;
   } dii_flit_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // flit field layout
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam int ID_W     = 10;  // dest in flit 0, source in flit 1
   localparam int TYPE_MSB = 15;  // packet type sits in flit 1
   localparam int TYPE_LSB = 12;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // packet type codes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam logic [3:0] REQ_READ_REG  = 4'd2;
   localparam logic [3:0] REQ_WRITE_REG = 4'd3;

   localparam logic [3:0] RESP_READ_REG        = 4'd8;
   localparam logic [3:0] RESP_READ_REG_ERROR  = 4'd9;
   localparam logic [3:0] RESP_WRITE_REG       = 4'd10;
   localparam logic [3:0] RESP_WRITE_REG_ERROR = 4'd11;

endpackage

// File: verilog/dbg_station.sv
`timescale 1ns/1ns

module dbg_station #(
   parameter logic [9:0]  BASE_ID     = 10'd1,
   parameter logic [15:0] SCM_VERSION = 16'h0001,
   parameter logic [15:0] TS_VERSION  = 16'h0001
) (
   input  logic               clk,
   input  logic               rst,
   input  dbg_pkg::dii_flit_t in_flit,
   output logic               in_ready,
   output dbg_pkg::dii_flit_t out_flit,
   input  logic               out_ready,
   output logic               sys_stall,
   output logic               sys_rst
);
   import dbg_pkg::*;
   import reg_pkg::*;

   dii_flit_t   port_in_flit [2];
   logic        port_in_ready [2];
   dii_flit_t   port_out_flit [2];
   logic        port_out_ready [2];

   reg_req_t    scm_req;
   logic [15:0] scm_rdata;
   logic        scm_err;
   reg_req_t    ts_req;
   logic [15:0] ts_rdata;
   logic        ts_err;

   dbg_station_router #(
      .BASE_ID (BASE_ID)
   ) router_inst (
      .clk            (clk),
      .rst            (rst),
      .in_flit        (in_flit),
      .in_ready       (in_ready),
      .out_flit       (out_flit),
      .out_ready      (out_ready),
      .port_in_flit   (port_in_flit),
      .port_in_ready  (port_in_ready),
      .port_out_flit  (port_out_flit),
      .port_out_ready (port_out_ready)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // system control module, port 0
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   reg_access_port #(
      .MOD_ID      (BASE_ID),
      .MOD_TYPE    (MOD_TYPE_SCM),
      .MOD_VERSION (SCM_VERSION)
   ) scm_port_inst (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (port_in_flit[0]),
      .in_ready  (port_in_ready[0]),
      .out_flit  (port_out_flit[0]),
      .out_ready (port_out_ready[0]),
      .reg_req   (scm_req),
      .reg_rdata (scm_rdata),
      .reg_err   (scm_err)
   );

   scm_regs scm_regs_inst (
      .clk       (clk),
      .rst       (rst),
      .reg_req   (scm_req),
      .reg_rdata (scm_rdata),
      .reg_err   (scm_err),
      .sys_stall (sys_stall),
      .sys_rst   (sys_rst)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // timestamp module, port 1
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   reg_access_port #(
      .MOD_ID      (BASE_ID + 10'd1),
      .MOD_TYPE    (MOD_TYPE_TIMESTAMP),
      .MOD_VERSION (TS_VERSION)
   ) ts_port_inst (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (port_in_flit[1]),
      .in_ready  (port_in_ready[1]),
      .out_flit  (port_out_flit[1]),
      .out_ready (port_out_ready[1]),
      .reg_req   (ts_req),
      .reg_rdata (ts_rdata),
      .reg_err   (ts_err)
   );

   timestamp_unit timestamp_inst (
      .clk       (clk),
      .rst       (rst),
      .reg_req   (ts_req),
      .reg_rdata (ts_rdata),
      .reg_err   (ts_err),
      .sys_stall (sys_stall)  // counter pauses with the system
   );

endmodule

// File: verilog/dbg_station_router.sv
`timescale 1ns/1ns

module dbg_station_router #(
   parameter logic [9:0] BASE_ID = 10'd1
) (
   input  logic               clk,
   input  logic               rst,
   input  dbg_pkg::dii_flit_t in_flit,
   output logic               in_ready,
   output dbg_pkg::dii_flit_t out_flit,
   input  logic               out_ready,
   output dbg_pkg::dii_flit_t port_in_flit [2],
   input  logic               port_in_ready [2],
   input  dbg_pkg::dii_flit_t port_out_flit [2],
   output logic               port_out_ready [2]
);
   import dbg_pkg::*;

   localparam logic [1:0] RT_P0   = 2'd0;
   localparam logic [1:0] RT_P1   = 2'd1;
   localparam logic [1:0] RT_DROP = 2'd2;

   logic [ID_W-1:0] dest;
   logic            in_active_q;
   logic [1:0]      in_route_q;
   logic [1:0]      in_route;
   logic            out_lock_q;
   logic            last_port_q;
   logic            out_sel;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // request side
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign dest = in_flit.data[ID_W-1:0];

   always_comb begin
      if (in_active_q) begin
         in_route = in_route_q;  // stay on the route picked by flit 0
      end else if (dest == BASE_ID) begin
         in_route = RT_P0;
      end else if (dest == BASE_ID + 10'd1) begin
         in_route = RT_P1;
      end else begin
         in_route = RT_DROP;
      end
   end

   always_comb begin
      in_ready = 1'b1;  // dropped flits are swallowed
      for (int i = 0; i < 2; i++) begin
         port_in_flit[i]       = in_flit;
         port_in_flit[i].valid = in_flit.valid & (in_route == 2'(i));
         if (in_route == 2'(i)) begin
            in_ready = port_in_ready[i];
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // response side
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      if (out_lock_q) begin
         out_sel = last_port_q;  // a packet in flight or a waiting flit keeps its port
      end else if (port_out_flit[0].valid && port_out_flit[1].valid) begin
         out_sel = ~last_port_q;
      end else begin
         out_sel = port_out_flit[1].valid;
      end
   end

   assign out_flit = port_out_flit[out_sel];

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         port_out_ready[i] = out_ready & (out_sel == 1'(i));
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         in_active_q <= 1'b0;
         in_route_q  <= RT_DROP;
         out_lock_q  <= 1'b0;
         last_port_q <= 1'b0;
      end else begin
         if (in_flit.valid && in_ready) begin
            in_active_q <= ~in_flit.last;
            in_route_q  <= in_route;
         end
         if (out_flit.valid) begin
            out_lock_q  <= ~(out_ready & out_flit.last);  // released only once last is taken
            last_port_q <= out_sel;
         end
      end
   end

endmodule

// File: verilog/reg_access_port.sv
`timescale 1ns/1ns

module reg_access_port #(
   parameter logic [9:0]  MOD_ID      = 10'd0,
   parameter logic [15:0] MOD_TYPE    = 16'h0000,
   parameter logic [15:0] MOD_VERSION = 16'h0000
) (
   input  logic               clk,
   input  logic               rst,
   input  dbg_pkg::dii_flit_t in_flit,
   output logic               in_ready,
   output dbg_pkg::dii_flit_t out_flit,
   input  logic               out_ready,
   output reg_pkg::reg_req_t  reg_req,
   input  logic [15:0]        reg_rdata,
   input  logic               reg_err
);
   import dbg_pkg::*;
   import reg_pkg::*;

   typedef enum logic [2:0] {
      ST_DEST, ST_HDR, ST_ADDR, ST_WDATA, ST_DROP, ST_TX0, ST_TX1, ST_TX2
   } state_t;

   state_t          state;
   state_t          state_nxt;
   logic [ID_W-1:0] src_q;
   logic            is_write_q;
   logic [15:0]     addr_q;
   logic [15:0]     value_q;
   logic            err_q;

   logic            acc;
   logic [15:0]     acc_addr;
   logic            mod_hit;
   logic            done;
   logic [15:0]     res_value;
   logic            res_err;
   logic [3:0]      resp_type;
   logic [3:0]      req_type;

   assign acc      = in_flit.valid & in_ready;
   assign req_type = in_flit.data[TYPE_MSB:TYPE_LSB];
   assign acc_addr = (state == ST_WDATA) ? addr_q : in_flit.data;  // write address was latched
   assign mod_hit  = (acc_addr >= REG_MOD_BASE);

   // the access happens on the final flit of a well-formed request only
   assign done = acc & in_flit.last &
                 (((state == ST_ADDR) & ~is_write_q) | (state == ST_WDATA));

   assign reg_req.valid = done & mod_hit;
   assign reg_req.write = (state == ST_WDATA);
   assign reg_req.addr  = acc_addr;
   assign reg_req.wdata = in_flit.data;

   always_comb begin
      res_value = 16'h0000;
      res_err   = 1'b1;
      if (mod_hit) begin
         res_err   = reg_err;
         res_value = reg_err ? 16'h0000 : reg_rdata;
      end else if (acc_addr == REG_MODID) begin
         res_err   = is_write_q;  // identity registers are read only
         res_value = MOD_TYPE;
      end else if (acc_addr == REG_VERSION) begin
         res_err   = is_write_q;
         res_value = MOD_VERSION;
      end
   end

   always_comb begin
      case ({is_write_q, err_q})
         2'b00:   resp_type = RESP_READ_REG;
         2'b01:   resp_type = RESP_READ_REG_ERROR;
         2'b10:   resp_type = RESP_WRITE_REG;
         default: resp_type = RESP_WRITE_REG_ERROR;
      endcase
   end

   always_comb begin
      state_nxt = state;
      in_ready  = 1'b0;
      out_flit  = '0;
      case (state)
         ST_DEST: begin
            in_ready = 1'b1;
            if (in_flit.valid) begin
               if (!in_flit.first) begin
                  state_nxt = in_flit.last ? ST_DEST : ST_DROP;
               end else if (!in_flit.last) begin
                  state_nxt = ST_HDR;
               end
            end
         end
         ST_HDR: begin
            in_ready = 1'b1;
            if (in_flit.valid) begin
               if (in_flit.last) begin
                  state_nxt = ST_DEST;  // ended early
               end else if (req_type == REQ_READ_REG || req_type == REQ_WRITE_REG) begin
                  state_nxt = ST_ADDR;
               end else begin
                  state_nxt = ST_DROP;
               end
            end
         end
         ST_ADDR: begin
            in_ready = 1'b1;
            if (in_flit.valid) begin
               if (is_write_q) begin
                  state_nxt = in_flit.last ? ST_DEST : ST_WDATA;
               end else begin
                  state_nxt = in_flit.last ? ST_TX0 : ST_DROP;
               end
            end
         end
         ST_WDATA: begin
            in_ready = 1'b1;
            if (in_flit.valid) begin
               state_nxt = in_flit.last ? ST_TX0 : ST_DROP;
            end
         end
         ST_DROP: begin
            in_ready = 1'b1;
            if (in_flit.valid && in_flit.last) begin
               state_nxt = ST_DEST;
            end
         end
         ST_TX0: begin
            out_flit.valid = 1'b1;
            out_flit.first = 1'b1;
            out_flit.data  = {6'h00, src_q};  // answer goes back to the requester
            if (out_ready) begin
               state_nxt = ST_TX1;
            end
         end
         ST_TX1: begin
            out_flit.valid = 1'b1;
            out_flit.last  = is_write_q;
            out_flit.data  = {resp_type, 2'b00, MOD_ID};
            if (out_ready) begin
               state_nxt = is_write_q ? ST_DEST : ST_TX2;
            end
         end
         default: begin
            out_flit.valid = 1'b1;
            out_flit.last  = 1'b1;
            out_flit.data  = value_q;
            if (out_ready) begin
               state_nxt = ST_DEST;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_DEST;
      end else begin
         state <= state_nxt;
      end
      if (acc && state == ST_HDR) begin
         src_q      <= in_flit.data[ID_W-1:0];
         is_write_q <= (req_type == REQ_WRITE_REG);
      end
      if (acc && state == ST_ADDR) begin
         addr_q <= in_flit.data;
      end
      if (done) begin
         value_q <= res_value;
         err_q   <= res_err;
      end
   end

endmodule

// File: verilog/reg_pkg.sv
package reg_pkg;

   typedef struct packed {
      logic        valid;  // high for exactly one cycle per access
      logic        write;
      logic [15:0] addr;
      logic [15:0] wdata;
   } reg_req_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // common registers, served by the access port itself
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam logic [15:0] REG_MODID    = 16'h0000;
   localparam logic [15:0] REG_VERSION  = 16'h0001;
   localparam logic [15:0] REG_MOD_BASE = 16'h0200;  // first address of the register block

   localparam logic [15:0] MOD_TYPE_SCM       = 16'h0001;
   localparam logic [15:0] MOD_TYPE_TIMESTAMP = 16'h0004;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // module registers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam logic [15:0] SCM_STALL   = 16'h0200;
   localparam logic [15:0] SCM_RST     = 16'h0201;
   localparam logic [15:0] SCM_SCRATCH = 16'h0202;

   localparam logic [15:0] TS_CTRL     = 16'h0200;  // bit 0 enable, bit 1 clear
   localparam logic [15:0] TS_COUNT_LO = 16'h0201;
   localparam logic [15:0] TS_COUNT_HI = 16'h0202;

endpackage

// File: verilog/scm_regs.sv
`timescale 1ns/1ns

module scm_regs (
   input  logic              clk,
   input  logic              rst,
   input  reg_pkg::reg_req_t reg_req,
   output logic [15:0]       reg_rdata,
   output logic              reg_err,
   output logic              sys_stall,
   output logic              sys_rst
);
   import reg_pkg::*;

   logic [15:0] scratch;
   logic        wr_en;

   always_comb begin
      reg_rdata = 16'h0000;
      reg_err   = 1'b0;
      case (reg_req.addr)
         SCM_STALL:   reg_rdata = {15'h0000, sys_stall};
         SCM_RST:     reg_rdata = {15'h0000, sys_rst};
         SCM_SCRATCH: reg_rdata = scratch;
         default:     reg_err   = 1'b1;
      endcase
   end

   assign wr_en = reg_req.valid & reg_req.write & ~reg_err;  // bad address leaves state alone

   always_ff @(posedge clk) begin
      if (rst) begin
         sys_stall <= 1'b0;
         sys_rst   <= 1'b0;
      end else if (wr_en) begin
         if (reg_req.addr == SCM_STALL) begin
            sys_stall <= reg_req.wdata[0];
         end
         if (reg_req.addr == SCM_RST) begin
            sys_rst <= reg_req.wdata[0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en && reg_req.addr == SCM_SCRATCH) begin
         scratch <= reg_req.wdata;
      end
   end

endmodule

// File: verilog/timestamp_unit.sv
`timescale 1ns/1ns

module timestamp_unit (
   input  logic              clk,
   input  logic              rst,
   input  reg_pkg::reg_req_t reg_req,
   output logic [15:0]       reg_rdata,
   output logic              reg_err,
   input  logic              sys_stall
);
   import reg_pkg::*;

   logic        enable;
   logic [31:0] count;
   logic [15:0] hi_snap;
   logic        wr_ctrl;
   logic        rd_lo;

   always_comb begin
      reg_rdata = 16'h0000;
      reg_err   = 1'b0;
      case (reg_req.addr)
         TS_CTRL:     reg_rdata = {15'h0000, enable};
         TS_COUNT_LO: reg_rdata = count[15:0];
         TS_COUNT_HI: reg_rdata = hi_snap;
         default:     reg_err   = 1'b1;
      endcase
   end

   assign wr_ctrl = reg_req.valid & reg_req.write & (reg_req.addr == TS_CTRL);
   assign rd_lo   = reg_req.valid & ~reg_req.write & (reg_req.addr == TS_COUNT_LO);

   always_ff @(posedge clk) begin
      if (rst) begin
         enable <= 1'b0;
         count  <= 32'h0000_0000;
      end else begin
         if (wr_ctrl) begin
            enable <= reg_req.wdata[0];
         end
         if (wr_ctrl && reg_req.wdata[1]) begin
            count <= 32'h0000_0000;  // clear wins over counting
         end else if (enable && !sys_stall) begin
            count <= count + 32'd1;
         end
      end
   end

   // high half is frozen when the low half is read so a 32-bit value is coherent
   always_ff @(posedge clk) begin
      if (rd_lo) begin
         hi_snap <= count[31:16];
      end
   end

endmodule
